// ==== sys_pkg.sv ====
package sys_pkg;

   // ======================================================================
   // Widths
   // ======================================================================
   localparam int XLEN       = 32;
   localparam int CSR_ADDR_W = 12;
   localparam int REG_ADDR_W = 5;

   // ======================================================================
   // Machine-mode CSR addresses
   // ======================================================================
   localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
   localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
   localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
   localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
   localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
   localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL    = 12'h343;

   // Stored mstatus bits
   localparam int MSTATUS_MIE_BIT  = 3;
   localparam int MSTATUS_MPIE_BIT = 7;

   // Trap causes
   localparam logic [XLEN-1:0] CAUSE_ILLEGAL = 32'h0000_0002;
   localparam logic [XLEN-1:0] CAUSE_BREAK   = 32'h0000_0003;
   localparam logic [XLEN-1:0] CAUSE_ECALL   = 32'h0000_000b;

   // ======================================================================
   // Instruction encoding
   // ======================================================================
   localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

   localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
   localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
   localparam logic [11:0] FUNCT12_MRET   = 12'h302;
   localparam logic [11:0] FUNCT12_WFI    = 12'h105;

   typedef enum logic [2:0] {
      OP_CSR_WRITE = 3'd0,
      OP_CSR_SET   = 3'd1,
      OP_CSR_CLEAR = 3'd2,
      OP_ECALL     = 3'd3,
      OP_EBREAK    = 3'd4,
      OP_MRET      = 3'd5,
      OP_WFI       = 3'd6,
      OP_ILLEGAL   = 3'd7
   } sys_op_e;

   // One SYSTEM word, seen either as a CSR access or a privileged op
   typedef union packed {
      struct packed {
         logic [CSR_ADDR_W-1:0] csr_addr;
         logic [REG_ADDR_W-1:0] src;
         logic [2:0]            funct3;
         logic [REG_ADDR_W-1:0] rd;
         logic [6:0]            opcode;
      } csr_view;
      struct packed {
         logic [11:0]           funct12;
         logic [REG_ADDR_W-1:0] rs1;
         logic [2:0]            funct3;
         logic [REG_ADDR_W-1:0] rd;
         logic [6:0]            opcode;
      } priv_view;
   } sys_insn_u;

endpackage

// ==== csr_file.sv ====
module csr_file #(
   parameter logic [sys_pkg::XLEN-1:0] MTVEC_RESET = '0
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [sys_pkg::CSR_ADDR_W-1:0]    csr_addr_i,
   input  logic                              csr_we_i,
   input  logic [sys_pkg::XLEN-1:0]          csr_wdata_i,
   output logic [sys_pkg::XLEN-1:0]          csr_rdata_o,
   output logic                              csr_exists_o
);
   import sys_pkg::*;

   // Only MIE and MPIE exist in mstatus
   logic             mie_q;
   logic             mpie_q;
   logic [XLEN-1:0]  mtvec_q;
   logic [XLEN-1:0]  mscratch_q;
   logic [XLEN-1:0]  mepc_q;
   logic [XLEN-1:0]  mcause_q;
   logic [XLEN-1:0]  mtval_q;

   // ======================================================================
   // Read port
   // ======================================================================
   always_comb begin
      csr_rdata_o  = '0;
      csr_exists_o = 1'b1;
      case (csr_addr_i)
         CSR_MSTATUS: begin
            csr_rdata_o[MSTATUS_MIE_BIT]  = mie_q;
            csr_rdata_o[MSTATUS_MPIE_BIT] = mpie_q;
         end
         CSR_MTVEC:    csr_rdata_o = mtvec_q;
         CSR_MSCRATCH: csr_rdata_o = mscratch_q;
         CSR_MEPC:     csr_rdata_o = mepc_q;
         CSR_MCAUSE:   csr_rdata_o = mcause_q;
         CSR_MTVAL:    csr_rdata_o = mtval_q;
         default:      csr_exists_o = 1'b0;
      endcase
   end

   // ======================================================================
   // Write port
   // ======================================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         mie_q      <= 1'b0;
         mpie_q     <= 1'b0;
         mtvec_q    <= MTVEC_RESET;
         mscratch_q <= '0;
         mepc_q     <= '0;
         mcause_q   <= '0;
         mtval_q    <= '0;
      end else if (csr_we_i) begin
         case (csr_addr_i)
            CSR_MSTATUS: begin
               mie_q  <= csr_wdata_i[MSTATUS_MIE_BIT];
               mpie_q <= csr_wdata_i[MSTATUS_MPIE_BIT];
            end
            CSR_MTVEC:    mtvec_q    <= csr_wdata_i;
            CSR_MSCRATCH: mscratch_q <= csr_wdata_i;
            CSR_MEPC:     mepc_q     <= csr_wdata_i;
            CSR_MCAUSE:   mcause_q   <= csr_wdata_i;
            CSR_MTVAL:    mtval_q    <= csr_wdata_i;
            default: begin
            end
         endcase
      end
   end

endmodule

// ==== sys_decode.sv ====
module sys_decode (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              start_i,
   input  sys_pkg::sys_insn_u                insn_i,
   input  logic [sys_pkg::XLEN-1:0]          rs1_val_i,
   input  logic [sys_pkg::XLEN-1:0]          pc_i,
   output logic                              op_valid_o,
   output sys_pkg::sys_op_e                  op_o,
   output logic [sys_pkg::CSR_ADDR_W-1:0]    csr_addr_o,
   output logic [sys_pkg::XLEN-1:0]          src_val_o,
   output logic [sys_pkg::REG_ADDR_W-1:0]    rd_o,
   output logic [sys_pkg::XLEN-1:0]          pc_o
);
   import sys_pkg::*;

   sys_op_e          op_d;
   logic [XLEN-1:0]  src_d;

   // Classify the word
   always_comb begin
      op_d = OP_ILLEGAL;
      // funct3[2] selects the zimm forms
      if (insn_i.csr_view.funct3[2]) begin
         src_d = {{(XLEN-REG_ADDR_W){1'b0}}, insn_i.csr_view.src};
      end else begin
         src_d = rs1_val_i;
      end
      if (insn_i.priv_view.opcode == OPCODE_SYSTEM) begin
         case (insn_i.csr_view.funct3)
            3'd0: begin
               case (insn_i.priv_view.funct12)
                  FUNCT12_ECALL:  op_d = OP_ECALL;
                  FUNCT12_EBREAK: op_d = OP_EBREAK;
                  FUNCT12_MRET:   op_d = OP_MRET;
                  FUNCT12_WFI:    op_d = OP_WFI;
                  default:        op_d = OP_ILLEGAL;
               endcase
            end
            3'd1, 3'd5: op_d = OP_CSR_WRITE;
            3'd2, 3'd6: op_d = OP_CSR_SET;
            3'd3, 3'd7: op_d = OP_CSR_CLEAR;
            default:    op_d = OP_ILLEGAL;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         op_valid_o <= 1'b0;
      end else begin
         op_valid_o <= start_i;
      end
   end

   // Operands held until the next start
   always_ff @(posedge clk) begin
      if (start_i) begin
         op_o       <= op_d;
         csr_addr_o <= insn_i.csr_view.csr_addr;
         src_val_o  <= src_d;
         rd_o       <= insn_i.csr_view.rd;
         pc_o       <= pc_i;
      end
   end

endmodule

// ==== sys_execute.sv ====
module sys_execute #(
   parameter logic [sys_pkg::XLEN-1:0] MTVEC_RESET = '0
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              op_valid_i,
   input  sys_pkg::sys_op_e                  op_i,
   input  logic [sys_pkg::CSR_ADDR_W-1:0]    csr_addr_i,
   input  logic [sys_pkg::XLEN-1:0]          src_val_i,
   input  logic [sys_pkg::XLEN-1:0]          pc_i,
   output logic                              done_o,
   output logic                              rd_we_o,
   output logic                              trap_o,
   output logic [sys_pkg::XLEN-1:0]          rd_data_o,
   output logic [sys_pkg::XLEN-1:0]          next_pc_o
);
   import sys_pkg::*;

   localparam logic [2:0] IDLE        = 3'd0;
   localparam logic [2:0] CSR_RW      = 3'd1;
   localparam logic [2:0] TRAP_CAUSE  = 3'd2;
   localparam logic [2:0] TRAP_EPC    = 3'd3;
   localparam logic [2:0] TRAP_TVAL   = 3'd4;
   localparam logic [2:0] TRAP_STATUS = 3'd5;

   logic [2:0]             state_q;
   logic [2:0]             state_d;
   logic [CSR_ADDR_W-1:0]  csr_addr;
   logic                   csr_we;
   logic [XLEN-1:0]        csr_wdata;
   logic [XLEN-1:0]        csr_rdata;
   logic                   csr_exists;
   // mtvec, or mepc for MRET, read while idle
   logic [XLEN-1:0]        hold_q;
   logic [XLEN-1:0]        target_pc;

   csr_file #(
      .MTVEC_RESET (MTVEC_RESET)
   ) u_csr_file (
      .clk          (clk),
      .reset        (reset),
      .csr_addr_i   (csr_addr),
      .csr_we_i     (csr_we),
      .csr_wdata_i  (csr_wdata),
      .csr_rdata_o  (csr_rdata),
      .csr_exists_o (csr_exists)
   );

   // ======================================================================
   // Sequencer, one CSR access per cycle
   // ======================================================================
   always_comb begin
      state_d   = state_q;
      csr_addr  = CSR_MTVEC;
      csr_we    = 1'b0;
      csr_wdata = '0;
      case (state_q)
         IDLE: begin
            if (op_i == OP_MRET) begin
               csr_addr = CSR_MEPC;
            end
            if (op_valid_i) begin
               case (op_i)
                  OP_CSR_WRITE, OP_CSR_SET, OP_CSR_CLEAR: state_d = CSR_RW;
                  OP_WFI:  state_d = IDLE;
                  OP_MRET: state_d = TRAP_STATUS;
                  default: state_d = TRAP_CAUSE;
               endcase
            end
         end
         CSR_RW: begin
            csr_addr = csr_addr_i;
            csr_we   = csr_exists;
            case (op_i)
               OP_CSR_SET:   csr_wdata = csr_rdata | src_val_i;
               OP_CSR_CLEAR: csr_wdata = csr_rdata & ~src_val_i;
               default:      csr_wdata = src_val_i;
            endcase
            // Missing CSR ends up as an illegal instruction
            state_d = csr_exists ? IDLE : TRAP_CAUSE;
         end
         TRAP_CAUSE: begin
            csr_addr = CSR_MCAUSE;
            csr_we   = 1'b1;
            case (op_i)
               OP_ECALL:  csr_wdata = CAUSE_ECALL;
               OP_EBREAK: csr_wdata = CAUSE_BREAK;
               default:   csr_wdata = CAUSE_ILLEGAL;
            endcase
            state_d = TRAP_EPC;
         end
         TRAP_EPC: begin
            csr_addr  = CSR_MEPC;
            csr_we    = 1'b1;
            csr_wdata = pc_i;
            state_d   = TRAP_TVAL;
         end
         TRAP_TVAL: begin
            csr_addr  = CSR_MTVAL;
            csr_we    = 1'b1;
            csr_wdata = pc_i;
            state_d   = TRAP_STATUS;
         end
         TRAP_STATUS: begin
            csr_addr = CSR_MSTATUS;
            csr_we   = 1'b1;
            if (op_i == OP_MRET) begin
               csr_wdata[MSTATUS_MIE_BIT]  = csr_rdata[MSTATUS_MPIE_BIT];
               csr_wdata[MSTATUS_MPIE_BIT] = csr_rdata[MSTATUS_MPIE_BIT];
            end else begin
               csr_wdata[MSTATUS_MPIE_BIT] = csr_rdata[MSTATUS_MIE_BIT];
            end
            state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk) begin
      if ((state_q == IDLE) && op_valid_i) begin
         hold_q <= csr_rdata;
      end
   end

   // ======================================================================
   // Response
   // ======================================================================
   assign done_o = ((state_q == IDLE) && op_valid_i && (op_i == OP_WFI))
                   || ((state_q == CSR_RW) && csr_exists)
                   || (state_q == TRAP_STATUS);

   assign rd_we_o   = (state_q == CSR_RW) && csr_exists;
   assign rd_data_o = (state_q == CSR_RW) ? csr_rdata : '0;
   assign trap_o    = (state_q == TRAP_STATUS) && (op_i != OP_MRET);

   assign target_pc = (state_q == TRAP_STATUS) ? hold_q : pc_i + XLEN'(4);
   assign next_pc_o = {target_pc[XLEN-1:1], 1'b0};

endmodule

// ==== sys_result.sv ====
module sys_result (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              req_i,
   input  logic                              done_i,
   input  logic                              rd_we_i,
   input  logic                              trap_i,
   input  logic [sys_pkg::REG_ADDR_W-1:0]    rd_addr_i,
   input  logic [sys_pkg::XLEN-1:0]          rd_data_i,
   input  logic [sys_pkg::XLEN-1:0]          next_pc_i,
   output logic                              start_o,
   output logic                              ack_o,
   output logic                              rd_we_o,
   output logic                              trap_o,
   output logic [sys_pkg::REG_ADDR_W-1:0]    rd_addr_o,
   output logic [sys_pkg::XLEN-1:0]          rd_data_o,
   output logic [sys_pkg::XLEN-1:0]          next_pc_o
);

   localparam logic [1:0] IDLE = 2'd0;
   localparam logic [1:0] WAIT = 2'd1;
   localparam logic [1:0] ACK  = 2'd2;

   logic [1:0] state_q;

   // Four-phase handshake
   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= IDLE;
      end else begin
         case (state_q)
            IDLE:    state_q <= req_i ? WAIT : IDLE;
            WAIT:    state_q <= done_i ? ACK : WAIT;
            ACK:     state_q <= req_i ? ACK : IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   assign start_o = (state_q == IDLE) && req_i;
   assign ack_o   = (state_q == ACK);

   // Held through the whole acknowledge phase
   always_ff @(posedge clk) begin
      if ((state_q == WAIT) && done_i) begin
         rd_we_o   <= rd_we_i;
         trap_o    <= trap_i;
         rd_addr_o <= rd_addr_i;
         rd_data_o <= rd_data_i;
         next_pc_o <= next_pc_i;
      end
   end

endmodule

// ==== sys_unit.sv ====
module sys_unit #(
   parameter logic [sys_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              req_i,
   input  sys_pkg::sys_insn_u                insn_i,
   input  logic [sys_pkg::XLEN-1:0]          rs1_val_i,
   input  logic [sys_pkg::XLEN-1:0]          pc_i,
   output logic                              ack_o,
   output logic                              rd_we_o,
   output logic                              trap_o,
   output logic [sys_pkg::REG_ADDR_W-1:0]    rd_addr_o,
   output logic [sys_pkg::XLEN-1:0]          rd_data_o,
   output logic [sys_pkg::XLEN-1:0]          next_pc_o
);
   import sys_pkg::*;

   logic                   start;
   logic                   op_valid;
   sys_op_e                op;
   logic [CSR_ADDR_W-1:0]  csr_addr;
   logic [XLEN-1:0]        src_val;
   logic [REG_ADDR_W-1:0]  rd;
   logic [XLEN-1:0]        op_pc;
   logic                   done;
   logic                   ex_rd_we;
   logic                   ex_trap;
   logic [XLEN-1:0]        ex_rd_data;
   logic [XLEN-1:0]        ex_next_pc;

   sys_decode u_decode (
      .clk        (clk),
      .reset      (reset),
      .start_i    (start),
      .insn_i     (insn_i),
      .rs1_val_i  (rs1_val_i),
      .pc_i       (pc_i),
      .op_valid_o (op_valid),
      .op_o       (op),
      .csr_addr_o (csr_addr),
      .src_val_o  (src_val),
      .rd_o       (rd),
      .pc_o       (op_pc)
   );

   sys_execute #(
      .MTVEC_RESET (MTVEC_RESET)
   ) u_execute (
      .clk        (clk),
      .reset      (reset),
      .op_valid_i (op_valid),
      .op_i       (op),
      .csr_addr_i (csr_addr),
      .src_val_i  (src_val),
      .pc_i       (op_pc),
      .done_o     (done),
      .rd_we_o    (ex_rd_we),
      .trap_o     (ex_trap),
      .rd_data_o  (ex_rd_data),
      .next_pc_o  (ex_next_pc)
   );

   sys_result u_result (
      .clk       (clk),
      .reset     (reset),
      .req_i     (req_i),
      .done_i    (done),
      .rd_we_i   (ex_rd_we),
      .trap_i    (ex_trap),
      .rd_addr_i (rd),
      .rd_data_i (ex_rd_data),
      .next_pc_i (ex_next_pc),
      .start_o   (start),
      .ack_o     (ack_o),
      .rd_we_o   (rd_we_o),
      .trap_o    (trap_o),
      .rd_addr_o (rd_addr_o),
      .rd_data_o (rd_data_o),
      .next_pc_o (next_pc_o)
   );

endmodule

// ==== sys_unit_properties.sv ====
module sys_unit_properties (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              req_i,
   input  logic                              ack_i,
   input  logic                              rd_we_i,
   input  logic                              trap_i,
   input  logic [sys_pkg::REG_ADDR_W-1:0]    rd_addr_i,
   input  logic [sys_pkg::XLEN-1:0]          rd_data_i,
   input  logic [sys_pkg::XLEN-1:0]          next_pc_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_count = 0;

   // ======================================================================
   // Four-phase handshake
   // ======================================================================
   ack_low_after_reset: assert property (@(posedge clk) reset |=> !ack_i)
      else begin
         $error("ack_o high in the cycle after reset");
         fail_count++;
      end

   // Request was seen when the unit decided to acknowledge
   ack_rise_needs_req: assert property (@(posedge clk) disable iff (reset)
      $rose(ack_i) |-> $past(req_i))
      else begin
         $error("ack_o rose without req_i high");
         fail_count++;
      end

   ack_held_while_req: assert property (@(posedge clk) disable iff (reset)
      ack_i && req_i |=> ack_i)
      else begin
         $error("ack_o dropped while req_i was still high");
         fail_count++;
      end

   response_stable: assert property (@(posedge clk) disable iff (reset)
      $past(ack_i) && ack_i |-> $stable(rd_we_i) && $stable(trap_i)
      && $stable(rd_addr_i) && $stable(rd_data_i) && $stable(next_pc_i))
      else begin
         $error("response changed while ack_o was high");
         fail_count++;
      end

endmodule

// ==== tb_sys_unit.sv ====
module tb_sys_unit;
   timeunit 1ns;
   timeprecision 1ps;
   import sys_pkg::*;

   localparam logic [XLEN-1:0] MTVEC_RESET  = 32'h0000_0100;
   localparam logic [XLEN-1:0] MSTATUS_MASK = (32'd1 << MSTATUS_MIE_BIT)
                                              | (32'd1 << MSTATUS_MPIE_BIT);
   localparam int              TIMEOUT      = 50;

   logic                   clk;
   logic                   reset;
   logic                   req_i;
   sys_insn_u              insn_i;
   logic [XLEN-1:0]        rs1_val_i;
   logic [XLEN-1:0]        pc_i;
   logic                   ack_o;
   logic                   rd_we_o;
   logic                   trap_o;
   logic [REG_ADDR_W-1:0]  rd_addr_o;
   logic [XLEN-1:0]        rd_data_o;
   logic [XLEN-1:0]        next_pc_o;

   logic [31:0]            lfsr_q = 32'h680b38f7;
   // Reference copy of the six machine-mode CSRs
   logic [XLEN-1:0]        model_csr [logic [CSR_ADDR_W-1:0]];
   int                     errors;
   int                     test_start_errors;
   int                     tests_run;
   int                     tests_failed;

   sys_unit #(
      .MTVEC_RESET (MTVEC_RESET)
   ) DUT (
      .clk       (clk),
      .reset     (reset),
      .req_i     (req_i),
      .insn_i    (insn_i),
      .rs1_val_i (rs1_val_i),
      .pc_i      (pc_i),
      .ack_o     (ack_o),
      .rd_we_o   (rd_we_o),
      .trap_o    (trap_o),
      .rd_addr_o (rd_addr_o),
      .rd_data_o (rd_data_o),
      .next_pc_o (next_pc_o)
   );

   bind sys_unit sys_unit_properties u_props (
      .clk       (clk),
      .reset     (reset),
      .req_i     (req_i),
      .ack_i     (ack_o),
      .rd_we_i   (rd_we_o),
      .trap_i    (trap_o),
      .rd_addr_i (rd_addr_o),
      .rd_data_i (rd_data_o),
      .next_pc_i (next_pc_o)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // ======================================================================
   // Stimulus helpers
   // ======================================================================
   // Taps 32, 22, 2, 1
   function automatic logic [31:0] rand_bits(input int count);
      logic [31:0] value;
      logic        feedback;
      value = '0;
      for (int i = 0; i < count; i++) begin
         feedback = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q   = {lfsr_q[30:0], feedback};
         value    = {value[30:0], feedback};
      end
      return value;
   endfunction

   function automatic sys_insn_u csr_insn(input logic [2:0] funct3,
                                         input logic [CSR_ADDR_W-1:0] addr,
                                         input logic [REG_ADDR_W-1:0] src,
                                         input logic [REG_ADDR_W-1:0] rd);
      sys_insn_u word;
      word.csr_view.csr_addr = addr;
      word.csr_view.src      = src;
      word.csr_view.funct3   = funct3;
      word.csr_view.rd       = rd;
      word.csr_view.opcode   = OPCODE_SYSTEM;
      return word;
   endfunction

   function automatic sys_insn_u priv_insn(input logic [11:0] funct12);
      sys_insn_u word;
      word.priv_view.funct12 = funct12;
      word.priv_view.rs1     = '0;
      word.priv_view.funct3  = 3'd0;
      word.priv_view.rd      = '0;
      word.priv_view.opcode  = OPCODE_SYSTEM;
      return word;
   endfunction

   // mstatus keeps only MIE and MPIE
   function automatic void model_write(input logic [CSR_ADDR_W-1:0] addr,
                                       input logic [XLEN-1:0] value);
      model_csr[addr] = (addr == CSR_MSTATUS) ? (value & MSTATUS_MASK) : value;
   endfunction

   task automatic check_value(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
      assert (got === exp) else begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic wait_ack(input logic level);
      int cycles;
      cycles = 0;
      while (ack_o !== level && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (ack_o !== level) begin
         $display("ack_o did not %s within %0d cycles, stopping the run",
                  level ? "rise" : "fall", TIMEOUT);
         $display("=== FAIL ===");
         $finish;
      end
   endtask

   // Raise req and wait for ack, optionally holding req longer
   task automatic start_op(input sys_insn_u word, input logic [XLEN-1:0] rs1,
                           input logic [XLEN-1:0] pc, input int hold);
      logic [XLEN-1:0] held_data;
      logic [XLEN-1:0] held_pc;
      @(negedge clk);
      insn_i    = word;
      rs1_val_i = rs1;
      pc_i      = pc;
      req_i     = 1'b1;
      wait_ack(1'b1);
      held_data = rd_data_o;
      held_pc   = next_pc_o;
      if (hold > 0) begin
         repeat (hold) @(negedge clk);
         check_value("ack_o", XLEN'(ack_o), 32'd1);
         check_value("rd_data_o", rd_data_o, held_data);
         check_value("next_pc_o", next_pc_o, held_pc);
      end
   endtask

   task automatic end_op();
      req_i = 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic check_response(input logic rd_we, input logic trap,
                                 input logic [XLEN-1:0] next_pc);
      check_value("rd_we_o", XLEN'(rd_we_o), XLEN'(rd_we));
      check_value("trap_o", XLEN'(trap_o), XLEN'(trap));
      check_value("next_pc_o", next_pc_o, next_pc & ~32'd1);
   endtask

   task automatic enter_trap(input logic [XLEN-1:0] cause, input logic [XLEN-1:0] pc);
      logic [XLEN-1:0] new_status;
      check_response(1'b0, 1'b1, model_csr[CSR_MTVEC]);
      new_status = '0;
      new_status[MSTATUS_MPIE_BIT] = model_csr[CSR_MSTATUS][MSTATUS_MIE_BIT];
      model_write(CSR_MCAUSE, cause);
      model_write(CSR_MEPC, pc);
      model_write(CSR_MTVAL, pc);
      model_write(CSR_MSTATUS, new_status);
   endtask

   task automatic csr_op(input logic [2:0] funct3, input logic [CSR_ADDR_W-1:0] addr,
                         input logic [XLEN-1:0] rs1, input int hold);
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] zimm;
      logic [XLEN-1:0]       pc;
      logic [XLEN-1:0]       src;
      logic [XLEN-1:0]       old;
      rd   = REG_ADDR_W'(rand_bits(REG_ADDR_W));
      zimm = REG_ADDR_W'(rand_bits(REG_ADDR_W));
      pc   = rand_bits(XLEN);
      src  = funct3[2] ? XLEN'(zimm) : rs1;
      start_op(csr_insn(funct3, addr, zimm, rd), rs1, pc, hold);
      if (funct3 != 3'd4 && model_csr.exists(addr)) begin
         old = model_csr[addr];
         check_value("rd_data_o", rd_data_o, old);
         check_value("rd_addr_o", XLEN'(rd_addr_o), XLEN'(rd));
         check_response(1'b1, 1'b0, pc + 32'd4);
         case (funct3[1:0])
            2'd1:    model_write(addr, src);
            2'd2:    model_write(addr, old | src);
            default: model_write(addr, old & ~src);
         endcase
      end else begin
         enter_trap(CAUSE_ILLEGAL, pc);
      end
      end_op();
   endtask

   task automatic priv_op(input logic [11:0] funct12);
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] new_status;
      pc = rand_bits(XLEN);
      start_op(priv_insn(funct12), rand_bits(XLEN), pc, 0);
      case (funct12)
         FUNCT12_ECALL:  enter_trap(CAUSE_ECALL, pc);
         FUNCT12_EBREAK: enter_trap(CAUSE_BREAK, pc);
         FUNCT12_MRET: begin
            check_response(1'b0, 1'b0, model_csr[CSR_MEPC]);
            new_status = model_csr[CSR_MSTATUS];
            new_status[MSTATUS_MIE_BIT] = new_status[MSTATUS_MPIE_BIT];
            model_write(CSR_MSTATUS, new_status);
         end
         default: check_response(1'b0, 1'b0, pc + 32'd4);
      endcase
      end_op();
   endtask

   // CSRRS with a zero source leaves the CSR as it is
   task automatic read_csr(input logic [CSR_ADDR_W-1:0] addr);
      csr_op(3'd2, addr, '0, 0);
   endtask

   task automatic read_trap_csrs();
      read_csr(CSR_MCAUSE);
      read_csr(CSR_MEPC);
      read_csr(CSR_MTVAL);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_start_errors) begin
         $display("Test %0d %s done, ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s done, %0d errors", tests_run, name, errors - test_start_errors);
      end
      test_start_errors = errors;
   endtask

   // ======================================================================
   // Test sequence
   // ======================================================================
   initial begin
      errors            = 0;
      test_start_errors = 0;
      tests_run         = 0;
      tests_failed      = 0;
      reset             = 1'b1;
      req_i             = 1'b0;
      insn_i            = '0;
      rs1_val_i         = '0;
      pc_i              = '0;
      model_csr[CSR_MSTATUS]  = '0;
      model_csr[CSR_MTVEC]    = MTVEC_RESET;
      model_csr[CSR_MSCRATCH] = '0;
      model_csr[CSR_MEPC]     = '0;
      model_csr[CSR_MCAUSE]   = '0;
      model_csr[CSR_MTVAL]    = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      check_value("ack_o", XLEN'(ack_o), 32'd0);
      csr_op(3'd1, CSR_MSCRATCH, rand_bits(XLEN), 10);
      end_test("reset and handshake");

      for (int f = 1; f < 8; f++) begin
         if (f != 4) begin
            csr_op(3'(f), CSR_MSCRATCH, rand_bits(XLEN), 0);
         end
      end
      read_csr(CSR_MSCRATCH);
      end_test("csr operations");

      csr_op(3'd1, CSR_MTVEC, rand_bits(XLEN), 0);
      priv_op(FUNCT12_ECALL);
      read_trap_csrs();
      priv_op(FUNCT12_EBREAK);
      read_trap_csrs();
      // Unimplemented CSR address, then funct3 4
      csr_op(3'd1, 12'h7c0, rand_bits(XLEN), 0);
      read_trap_csrs();
      csr_op(3'd4, CSR_MSCRATCH, rand_bits(XLEN), 0);
      read_trap_csrs();
      end_test("traps");

      // MIE set and MPIE clear, so the trap has to move MIE into MPIE
      csr_op(3'd1, CSR_MSTATUS, 32'hffff_ff7f, 0);
      read_csr(CSR_MSTATUS);
      priv_op(FUNCT12_ECALL);
      read_csr(CSR_MSTATUS);
      end_test("mstatus on trap");

      priv_op(FUNCT12_MRET);
      read_csr(CSR_MSTATUS);
      end_test("mret");

      priv_op(FUNCT12_WFI);
      read_csr(CSR_MSTATUS);
      read_csr(CSR_MTVEC);
      read_csr(CSR_MSCRATCH);
      read_trap_csrs();
      end_test("wfi");

      $display("Tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
               tests_run, tests_failed, errors, DUT.u_props.fail_count);
      if (errors == 0 && DUT.u_props.fail_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== build.f ====
sys_pkg.sv
csr_file.sv
sys_decode.sv
sys_execute.sv
sys_result.sv
sys_unit.sv
sys_unit_properties.sv
tb_sys_unit.sv

// ==== Bender.yml ====
package:
  name: sys_unit

sources:
  - sys_pkg.sv
  - csr_file.sv
  - sys_decode.sv
  - sys_execute.sv
  - sys_result.sv
  - sys_unit.sv
  - target: test
    files:
      - sys_unit_properties.sv
      - tb_sys_unit.sv
